/* common/pool_defines.svh */
/* Widths, sizes and register addresses shared by the 2x2 pooling engine.
   Included by any file that needs these values. */

`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// ************************************************************************
// Datapath sizes
// ************************************************************************

// Pixel width in bits
`define POOL_DATA_W 8

// Row store depth and largest legal line length
`define POOL_MAX_LINE 16

// Holds a line length of up to 16
`define POOL_LEN_W 5

// ************************************************************************
// Register map, 2-bit word address
// ************************************************************************

`define POOL_ADDR_CTRL 2'd0
`define POOL_ADDR_LEN 2'd1
`define POOL_ADDR_COUNT 2'd2

`endif

/* common/pool_pkg.sv */
/* Types for the pooling datapath. Modules import this package for the
   pixel element union and the reduction mode. */

`include "pool_defines.svh"

package pool_pkg;

	// ************************************************************************
	// Pixel element
	// ************************************************************************

	// One pixel word with two readings of the same bits
	// Compare logic picks the view from the signedness bit
	typedef union packed
	{
		logic signed [`POOL_DATA_W-1:0] s;
		logic [`POOL_DATA_W-1:0] u;
	} pool_elem_u;

	// ************************************************************************
	// Reduction mode
	// ************************************************************************

	// Matches CTRL bit 1
	typedef enum logic
	{
		MODE_MAX = 1'b0,
		MODE_MIN = 1'b1
	} pool_mode_e;

endpackage

/* hw/pool_compare_node.sv */
/* Two-input max or min picker with per-input valid bits. Used as a node
   of the pooling reduction tree. */

module pool_compare_node
(
	input pool_pkg::pool_mode_e mode,
	input logic is_signed,
	input logic a_valid,
	input pool_pkg::pool_elem_u a_data,
	input logic b_valid,
	input pool_pkg::pool_elem_u b_data,
	output logic y_valid,
	output pool_pkg::pool_elem_u y_data
);

	import pool_pkg::*;

	// b strictly above or below a, under the chosen view
	logic b_above;
	logic b_below;

	always_comb
	begin
		if (is_signed)
		begin
			b_above = b_data.s > a_data.s;
			b_below = b_data.s < a_data.s;
		end
		else
		begin
			b_above = b_data.u > a_data.u;
			b_below = b_data.u < a_data.u;
		end
	end

	// Either valid input makes a valid result
	assign y_valid = a_valid | b_valid;

	// Lone valid input passes through
	// Ties keep a, since only a strict win replaces it
	always_comb
	begin
		y_data = a_data;
		if (!a_valid)
		begin
			y_data = b_data;
		end
		else if (b_valid)
		begin
			if (mode == MODE_MAX)
			begin
				if (b_above)
					y_data = b_data;
			end
			else if (b_below)
			begin
				y_data = b_data;
			end
		end
	end

endmodule

/* hw/pool_reduce4.sv */
/* Reduces one 2x2 window to a single max or min value and registers it.
   Fed by the line buffer, result goes to the top-level output. */

module pool_reduce4
(
	input logic rvx_port_2,
	input logic rvx_port_5,
	input logic win_strobe,
	input logic [3:0] win_valid,
	input pool_pkg::pool_elem_u [3:0] win_data,
	input pool_pkg::pool_mode_e mode,
	input logic is_signed,
	output logic res_strobe,
	output logic res_valid,
	output pool_pkg::pool_elem_u res_data
);

	import pool_pkg::*;

	// Leaf results, upper row and lower row
	logic upper_valid;
	pool_elem_u upper_data;
	logic lower_valid;
	pool_elem_u lower_data;

	// Root result, captured on the window strobe
	logic root_valid;
	pool_elem_u root_data;

	// ************************************************************************
	// Compare tree
	// ************************************************************************

	// Elements 0 and 1, the row above
	pool_compare_node u_node_upper
	(
		.mode(mode),
		.is_signed(is_signed),
		.a_valid(win_valid[0]),
		.a_data(win_data[0]),
		.b_valid(win_valid[1]),
		.b_data(win_data[1]),
		.y_valid(upper_valid),
		.y_data(upper_data)
	);

	// Elements 2 and 3, the current row
	pool_compare_node u_node_lower
	(
		.mode(mode),
		.is_signed(is_signed),
		.a_valid(win_valid[2]),
		.a_data(win_data[2]),
		.b_valid(win_valid[3]),
		.b_data(win_data[3]),
		.y_valid(lower_valid),
		.y_data(lower_data)
	);

	pool_compare_node u_node_root
	(
		.mode(mode),
		.is_signed(is_signed),
		.a_valid(upper_valid),
		.a_data(upper_data),
		.b_valid(lower_valid),
		.b_data(lower_data),
		.y_valid(root_valid),
		.y_data(root_data)
	);

	// ************************************************************************
	// Result register
	// ************************************************************************

	// Strobe follows the window by one cycle, data holds between strobes
	always_ff @(posedge rvx_port_2 or negedge rvx_port_5)
	begin
		if (!rvx_port_5)
		begin
			res_strobe <= 1'b0;
			res_valid <= 1'b0;
			res_data <= '0;
		end
		else
		begin
			res_strobe <= win_strobe;
			if (win_strobe)
			begin
				res_valid <= root_valid;
				res_data <= root_data;
			end
		end
	end

	// Line buffer must never send an empty window
	a_win_not_empty: assert property (@(posedge rvx_port_2) disable iff (!rvx_port_5)
		win_strobe |-> (win_valid != 4'b0000))
		else $error("window strobe with no valid elements");

endmodule

/* hw/pool_window/pool_line_buffer.sv */
/* Keeps the even row of the image and builds one 2x2 window per column pair
   on each odd row. Feeds the reduction tree with a one-cycle window strobe. */

`include "pool_defines.svh"

module pool_line_buffer
(
	input logic rvx_port_2,
	input logic rvx_port_5,
	input logic enable,
	input logic [`POOL_LEN_W-1:0] line_len,
	input logic frame_start,
	input logic pix_strobe,
	input pool_pkg::pool_elem_u pix_data,
	output logic win_strobe,
	output logic [3:0] win_valid,
	output pool_pkg::pool_elem_u [3:0] win_data
);

	import pool_pkg::*;

	// Row store index width
	localparam int COL_IDX_W = $clog2(`POOL_MAX_LINE);

	// Position in the frame
	logic [`POOL_LEN_W-1:0] col_q;
	logic row_odd_q;

	// Even row pixels, one per column
	pool_elem_u row_mem [`POOL_MAX_LINE];

	// Left pixel of the current pair on the odd row
	pool_elem_u left_q;

	logic take;
	logic last_col;
	logic complete;
	logic [COL_IDX_W-1:0] col_idx;
	logic [COL_IDX_W-1:0] pair_idx;

	// ************************************************************************
	// Position tracking
	// ************************************************************************

	// Pixels only count while enabled
	assign take = pix_strobe & enable;
	assign last_col = (col_q == (line_len - `POOL_LEN_W'(1)));

	// Odd column closes a pair, last column of odd length closes a half pair
	assign complete = take & row_odd_q & (col_q[0] | last_col);

	assign col_idx = col_q[COL_IDX_W-1:0];
	// Even column that starts this pair
	assign pair_idx = {col_idx[COL_IDX_W-1:1], 1'b0};

	always_ff @(posedge rvx_port_2 or negedge rvx_port_5)
	begin
		if (!rvx_port_5)
		begin
			col_q <= '0;
			row_odd_q <= 1'b0;
		end
		else if (frame_start)
		begin
			col_q <= '0;
			row_odd_q <= 1'b0;
		end
		else if (take)
		begin
			if (last_col)
			begin
				// Wrap to next row, flip parity
				col_q <= '0;
				row_odd_q <= ~row_odd_q;
			end
			else
			begin
				col_q <= col_q + `POOL_LEN_W'(1);
			end
		end
	end

	// ************************************************************************
	// Row storage
	// ************************************************************************

	always_ff @(posedge rvx_port_2)
	begin
		// Even row goes into the store
		if (take && !row_odd_q)
			row_mem[col_idx] <= pix_data;
		// Odd row left pixel waits for its partner
		if (take && row_odd_q && !col_q[0])
			left_q <= pix_data;
	end

	// ************************************************************************
	// Window output
	// ************************************************************************

	always_ff @(posedge rvx_port_2 or negedge rvx_port_5)
	begin
		if (!rvx_port_5)
		begin
			win_strobe <= 1'b0;
			win_valid <= 4'b0000;
		end
		else
		begin
			win_strobe <= complete;
			if (complete)
				win_valid <= col_q[0] ? 4'b1111 : 4'b0101;
		end
	end

	always_ff @(posedge rvx_port_2)
	begin
		if (complete)
		begin
			if (col_q[0])
			begin
				// Full pair
				win_data[0] <= row_mem[pair_idx];
				win_data[1] <= row_mem[col_idx];
				win_data[2] <= left_q;
				win_data[3] <= pix_data;
			end
			else
			begin
				// Half pair at the end of an odd-length line
				win_data[0] <= row_mem[col_idx];
				win_data[1] <= '0;
				win_data[2] <= pix_data;
				win_data[3] <= '0;
			end
		end
	end

	a_len_range: assert property (@(posedge rvx_port_2) disable iff (!rvx_port_5)
		enable |-> (line_len >= `POOL_LEN_W'(2) && line_len <= `POOL_LEN_W'(`POOL_MAX_LINE)))
		else $error("line length out of range while enabled");

	a_start_alone: assert property (@(posedge rvx_port_2) disable iff (!rvx_port_5)
		!(frame_start && pix_strobe))
		else $error("frame start together with a pixel strobe");

endmodule

/* hw/pool_cfg_regs.sv */
/* Control, line length and window count registers of the pooling engine.
   Written and read over a simple strobe port, drives the datapath levels. */

`include "pool_defines.svh"

module pool_cfg_regs
(
	input logic rvx_port_2,
	input logic rvx_port_5,
	input logic reg_wr,
	input logic [1:0] reg_addr,
	input logic [15:0] reg_wdata,
	output logic [15:0] reg_rdata,
	input logic res_strobe,
	output logic enable,
	output pool_pkg::pool_mode_e mode,
	output logic is_signed,
	output logic [`POOL_LEN_W-1:0] line_len
);

	import pool_pkg::*;

	// CTRL bits, enable at 0, mode at 1, signed at 2
	logic [2:0] ctrl_q;
	logic [`POOL_LEN_W-1:0] len_q;
	// Output windows seen, wraps
	logic [15:0] count_q;

	// ************************************************************************
	// Register writes and window counter
	// ************************************************************************

	always_ff @(posedge rvx_port_2 or negedge rvx_port_5)
	begin
		if (!rvx_port_5)
		begin
			ctrl_q <= 3'b000;
			len_q <= '0;
			count_q <= 16'h0000;
		end
		else
		begin
			if (reg_wr && reg_addr == `POOL_ADDR_CTRL)
				ctrl_q <= reg_wdata[2:0];
			if (reg_wr && reg_addr == `POOL_ADDR_LEN)
				len_q <= reg_wdata[`POOL_LEN_W-1:0];
			// Any write to COUNT clears it, and wins over a result
			if (reg_wr && reg_addr == `POOL_ADDR_COUNT)
				count_q <= 16'h0000;
			else if (res_strobe)
				count_q <= count_q + 16'h0001;
		end
	end

	// Read mux, unmapped address reads zero
	always_comb
	begin
		case (reg_addr)
			`POOL_ADDR_CTRL: reg_rdata = {13'h0000, ctrl_q};
			`POOL_ADDR_LEN: reg_rdata = {{(16-`POOL_LEN_W){1'b0}}, len_q};
			`POOL_ADDR_COUNT: reg_rdata = count_q;
			default: reg_rdata = 16'h0000;
		endcase
	end

	// Levels to the datapath
	assign enable = ctrl_q[0];
	assign mode = ctrl_q[1] ? MODE_MIN : MODE_MAX;
	assign is_signed = ctrl_q[2];
	assign line_len = len_q;

endmodule

/* hw/pool_top.sv */
/* Top of the streaming 2x2 pooling engine. Register block, line buffer and
   reduction tree; a completing pixel gives a result two cycles later. */

`include "pool_defines.svh"

module pool_top
(
	input logic rvx_port_2,
	input logic rvx_port_5,
	input logic reg_wr,
	input logic [1:0] reg_addr,
	input logic [15:0] reg_wdata,
	output logic [15:0] reg_rdata,
	input logic frame_start,
	input logic pix_strobe,
	input logic [`POOL_DATA_W-1:0] pix_data,
	output logic pool_strobe,
	output logic pool_valid,
	output logic [`POOL_DATA_W-1:0] pool_data
);

	import pool_pkg::*;

	// Configuration levels
	logic enable;
	pool_mode_e mode;
	logic is_signed;
	logic [`POOL_LEN_W-1:0] line_len;

	// Window from line buffer to tree
	logic win_strobe;
	logic [3:0] win_valid;
	pool_elem_u [3:0] win_data;

	// ************************************************************************
	// Control
	// ************************************************************************

	// Counter steps on each result strobe
	pool_cfg_regs u_cfg_regs
	(
		.rvx_port_2(rvx_port_2),
		.rvx_port_5(rvx_port_5),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.res_strobe(pool_strobe),
		.enable(enable),
		.mode(mode),
		.is_signed(is_signed),
		.line_len(line_len)
	);

	// ************************************************************************
	// Datapath
	// ************************************************************************

	pool_line_buffer u_line_buffer
	(
		.rvx_port_2(rvx_port_2),
		.rvx_port_5(rvx_port_5),
		.enable(enable),
		.line_len(line_len),
		.frame_start(frame_start),
		.pix_strobe(pix_strobe),
		.pix_data(pix_data),
		.win_strobe(win_strobe),
		.win_valid(win_valid),
		.win_data(win_data)
	);

	pool_reduce4 u_reduce4
	(
		.rvx_port_2(rvx_port_2),
		.rvx_port_5(rvx_port_5),
		.win_strobe(win_strobe),
		.win_valid(win_valid),
		.win_data(win_data),
		.mode(mode),
		.is_signed(is_signed),
		.res_strobe(pool_strobe),
		.res_valid(pool_valid),
		.res_data(pool_data)
	);

endmodule

/* tb/tb_pool_top.sv */
/* Testbench for the 2x2 pooling engine. LFSR frames run through a window model,
   and each result must arrive two cycles after its completing pixel. */

`include "pool_defines.svh"

module tb_pool_top;

	timeunit 1ns;
	timeprecision 1ps;

	import pool_pkg::*;

	// DUT ports
	logic rvx_port_2;
	logic rvx_port_5;
	logic reg_wr;
	logic [1:0] reg_addr;
	logic [15:0] reg_wdata;
	logic [15:0] reg_rdata;
	logic frame_start;
	logic pix_strobe;
	logic [`POOL_DATA_W-1:0] pix_data;
	logic pool_strobe;
	logic pool_valid;
	logic [`POOL_DATA_W-1:0] pool_data;

	// Cycle count and bookkeeping
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int tests_bad = 0;
	int err_mark = 0;
	logic [31:0] lfsr_state = 32'h1ed8;

	// Model state that mirrors the register writes
	logic [7:0] m_row [16];
	logic [7:0] m_left;
	logic [4:0] m_col;
	logic [4:0] m_len;
	logic m_odd;
	logic m_en;
	logic m_min;
	logic m_signed;
	int m_windows;

	// Expected results with their due cycle
	pool_elem_u exp_data_q [$];
	int exp_due_q [$];
	pool_elem_u mon_data;
	int mon_due;

	pool_top u_pool_top
	(
		.rvx_port_2(rvx_port_2),
		.rvx_port_5(rvx_port_5),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.frame_start(frame_start),
		.pix_strobe(pix_strobe),
		.pix_data(pix_data),
		.pool_strobe(pool_strobe),
		.pool_valid(pool_valid),
		.pool_data(pool_data)
	);

	// 40 ns period
	always #20 rvx_port_2 = ~rvx_port_2;

	always @(posedge rvx_port_2)
		cyc <= cyc + 1;

	// ************************************************************************
	// Random bits and compare tasks
	// ************************************************************************

	// Galois LFSR on x^32 + x^22 + x^2 + x + 1 with one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	task automatic check_elem(input string name, input pool_elem_u got, input pool_elem_u exp);
		checks++;
		if (got.u !== exp.u)
		begin
			errors++;
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got.u, exp.u);
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_cycle(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("MISMATCH %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// ************************************************************************
	// Window model
	// ************************************************************************

	// Pixel as a number under the current signedness
	function automatic int view(input logic [7:0] p);
		if (m_signed)
			return int'($signed(p));
		else
			return int'(p);
	endfunction

	// True when y should replace x under the current mode
	function automatic bit better(input logic [7:0] x, input logic [7:0] y);
		if (m_min)
			return view(y) < view(x);
		else
			return view(y) > view(x);
	endfunction

	// Max or min over the valid elements only
	function automatic logic [7:0] window_result(input logic [7:0] e0, input logic [7:0] e1,
		input logic [7:0] e2, input logic [7:0] e3, input logic [3:0] v);
		logic [7:0] res;
		res = e0;
		if (v[1] && better(res, e1))
			res = e1;
		if (v[2] && better(res, e2))
			res = e2;
		if (v[3] && better(res, e3))
			res = e3;
		return res;
	endfunction

	task automatic push_result(input logic [7:0] v, input int due);
		pool_elem_u e;
		e.u = v;
		exp_data_q.push_back(e);
		exp_due_q.push_back(due);
		m_windows++;
	endtask

	// Even rows are stored, odd rows close a pair or a half pair
	task automatic model_pixel(input logic [7:0] v, input int due);
		logic last;
		last = (m_col == m_len - 5'd1);
		if (m_en)
		begin
			if (!m_odd)
				m_row[m_col[3:0]] = v;
			else if (m_col[0])
				push_result(window_result(m_row[m_col[3:0] - 4'd1], m_row[m_col[3:0]], m_left, v,
					4'b1111), due);
			else if (last)
				push_result(window_result(m_row[m_col[3:0]], 8'h00, v, 8'h00, 4'b0101), due);
			else
				m_left = v;
			if (last)
			begin
				m_col = '0;
				m_odd = ~m_odd;
			end
			else
			begin
				m_col = m_col + 5'd1;
			end
		end
	endtask

	// ************************************************************************
	// Drivers
	// ************************************************************************

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge rvx_port_2);
			pix_strobe <= 1'b0;
		end
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		@(posedge rvx_port_2);
		reg_wr <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		@(posedge rvx_port_2);
		reg_wr <= 1'b0;
		// Model follows the write from the next pixel on
		if (addr == `POOL_ADDR_CTRL)
		begin
			m_en = data[0];
			m_min = data[1];
			m_signed = data[2];
		end
		else if (addr == `POOL_ADDR_LEN)
			m_len = data[4:0];
		else if (addr == `POOL_ADDR_COUNT)
			m_windows = 0;
	endtask

	// Address set on the edge, data read mid-cycle
	task automatic read_reg(input logic [1:0] addr, input logic [15:0] exp, input string name);
		@(posedge rvx_port_2);
		reg_addr <= addr;
		@(negedge rvx_port_2);
		check_word(name, reg_rdata, exp);
	endtask

	task automatic start_frame();
		@(posedge rvx_port_2);
		frame_start <= 1'b1;
		pix_strobe <= 1'b0;
		@(posedge rvx_port_2);
		frame_start <= 1'b0;
		m_col = '0;
		m_odd = 1'b0;
	endtask

	// Due two cycles after the cycle the pixel is seen in
	task automatic send_pixel(input logic [7:0] v);
		@(posedge rvx_port_2);
		pix_strobe <= 1'b1;
		pix_data <= v;
		model_pixel(v, cyc + 3);
	endtask

	// Random gaps of 0 to 3 cycles unless dense
	task automatic send_run(input int n, input bit dense);
		logic [31:0] r;
		for (int i = 0; i < n; i++)
		begin
			if (!dense)
				idle(int'(rand_bits(2)));
			r = rand_bits(8);
			send_pixel(r[7:0]);
		end
		idle(1);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_due_q.size() != 0 && n < 100)
		begin
			@(posedge rvx_port_2);
			n++;
		end
		if (exp_due_q.size() != 0)
		begin
			errors++;
			$display("%0t: timeout, %0d expected results never arrived", $time, exp_due_q.size());
			exp_due_q.delete();
			exp_data_q.delete();
		end
	endtask

	task automatic run_frame(input int rows, input bit dense);
		start_frame();
		send_run(rows * int'(m_len), dense);
		wait_drain();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_mark)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			tests_bad++;
			$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// ************************************************************************
	// Result monitor
	// ************************************************************************

	// Sampled mid-cycle, every strobe must match the queue head
	always @(negedge rvx_port_2)
	begin
		if (rvx_port_5 && pool_strobe)
		begin
			if (exp_due_q.size() == 0)
			begin
				errors++;
				$display("%0t: pool_strobe with no result expected", $time);
			end
			else
			begin
				mon_data = exp_data_q.pop_front();
				mon_due = exp_due_q.pop_front();
				check_cycle("pool_strobe cycle", cyc, mon_due);
				check_bit("pool_valid", pool_valid, 1'b1);
				check_elem("pool_data", pool_data, mon_data);
			end
		end
	end

	// ************************************************************************
	// Test sequence
	// ************************************************************************

	initial
	begin
		rvx_port_2 = 1'b0;
		rvx_port_5 <= 1'b0;
		reg_wr <= 1'b0;
		reg_addr <= 2'd0;
		reg_wdata <= 16'h0000;
		frame_start <= 1'b0;
		pix_strobe <= 1'b0;
		pix_data <= 8'h00;
		m_col = '0;
		m_len = '0;
		m_odd = 1'b0;
		m_en = 1'b0;
		m_min = 1'b0;
		m_signed = 1'b0;
		m_windows = 0;
		repeat (3) @(posedge rvx_port_2);
		rvx_port_5 <= 1'b1;
		idle(2);

		// LEN goes in before enable since the range holds only while enabled
		write_reg(`POOL_ADDR_LEN, 16'd8);
		write_reg(`POOL_ADDR_CTRL, 16'h0001);
		run_frame(8, 1'b0);
		run_frame(8, 1'b0);
		end_test("unsigned max");

		// Signed min where uniform bytes cross 0x80 freely
		write_reg(`POOL_ADDR_CTRL, 16'h0007);
		run_frame(8, 1'b0);
		run_frame(8, 1'b0);
		end_test("signed min");

		// Half windows at column 6, the 7-row frame drops its last row
		// Unsigned min lets a zero in an empty slot win if it were counted
		write_reg(`POOL_ADDR_LEN, 16'd7);
		write_reg(`POOL_ADDR_CTRL, 16'h0003);
		run_frame(8, 1'b0);
		run_frame(7, 1'b0);
		end_test("odd line length");

		write_reg(`POOL_ADDR_LEN, 16'd8);
		write_reg(`POOL_ADDR_CTRL, 16'h0005);
		read_reg(`POOL_ADDR_CTRL, 16'h0005, "reg_rdata ctrl");
		read_reg(`POOL_ADDR_LEN, 16'd8, "reg_rdata len");
		write_reg(`POOL_ADDR_COUNT, 16'h0000);
		run_frame(8, 1'b0);
		read_reg(`POOL_ADDR_COUNT, 16'(m_windows), "reg_rdata count");
		write_reg(`POOL_ADDR_COUNT, 16'h1234);
		read_reg(`POOL_ADDR_COUNT, 16'h0000, "reg_rdata count cleared");
		end_test("register readback and counter");

		// Pause mid odd row, ignored pixels must not shift the window
		write_reg(`POOL_ADDR_CTRL, 16'h0001);
		start_frame();
		send_run(11, 1'b0);
		write_reg(`POOL_ADDR_CTRL, 16'h0000);
		send_run(6, 1'b0);
		write_reg(`POOL_ADDR_CTRL, 16'h0001);
		send_run(5, 1'b0);
		wait_drain();
		end_test("disable");

		// Full length, then length 5 with back to back window pairs
		write_reg(`POOL_ADDR_LEN, 16'd16);
		write_reg(`POOL_ADDR_CTRL, 16'h0003);
		run_frame(6, 1'b1);
		write_reg(`POOL_ADDR_LEN, 16'd5);
		run_frame(6, 1'b1);
		end_test("dense stream");

		// Catch stray strobes
		idle(6);
		$display("tests %0d, failing %0d, checks %0d, errors %0d", tests, tests_bad, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+common
common/pool_pkg.sv
hw/pool_compare_node.sv
hw/pool_reduce4.sv
hw/pool_window/pool_line_buffer.sv
hw/pool_cfg_regs.sv
hw/pool_top.sv
tb/tb_pool_top.sv

/* Makefile */
# Verilator flow for the 2x2 pooling engine

SIM = obj_dir/Vtb_pool_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_pool_top -f files.f

# Pass only when the log holds the pass line
run: build
	$(SIM) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module pool_top -f files.f

clean:
	rm -rf obj_dir sim.log
